// ==== logic/soc_pkg.sv ====
/*
 * SoC fabric package
 * Address map, bus widths, routing and FSM enums, and the packed
 * request and response structs shared by the host port and APB side
 */

package soc_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 64;
  localparam int unsigned STRB_W     = DATA_W / 8;
  localparam int unsigned APB_DATA_W = 32;

  //////////////////////////////////////////////////
  // Memory map
  //////////////////////////////////////////////////

  localparam logic [ADDR_W-1:0] DRAM_BASE   = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] DRAM_LENGTH = 32'h4000_0000;
  localparam logic [ADDR_W-1:0] UART_BASE   = 32'hC000_0000;
  localparam logic [ADDR_W-1:0] UART_LENGTH = 32'h0000_1000;
  localparam logic [ADDR_W-1:0] CTRL_BASE   = 32'hD000_0000;
  localparam logic [ADDR_W-1:0] CTRL_LENGTH = 32'h0000_1000;

  typedef enum logic [1:0] {
    TARGET_L2,
    TARGET_UART,
    TARGET_CTRL,
    TARGET_NONE
  } target_e;

  // Offsets inside the control window
  typedef enum logic [11:0] {
    CTRL_EXIT      = 12'h000,
    CTRL_HW_CNT_EN = 12'h008,
    CTRL_EVENT     = 12'h010
  } ctrl_reg_e;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] be;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } bus_rsp_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [ADDR_W-1:0]     paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

endpackage

// ==== logic/soc_addr_decode.sv ====
/*
 * Host port address decode
 * Matches the request address against the SoC windows, grants the
 * request and raises the select of the chosen target
 */

`timescale 1ns/1ps

module soc_addr_decode (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              req_i,
  input  soc_pkg::bus_req_t bus_i,
  input  logic              busy_i,
  output logic              gnt_o,
  output logic              l2_sel_o,
  output logic              ctrl_sel_o,
  output logic              uart_sel_o,
  output soc_pkg::target_e  target_o,
  output soc_pkg::bus_req_t bus_o
);

  logic accept;
  logic uart_pend_q;

  function automatic logic in_window(logic [soc_pkg::ADDR_W-1:0] addr,
                                     logic [soc_pkg::ADDR_W-1:0] base,
                                     logic [soc_pkg::ADDR_W-1:0] length);
    return (addr >= base) && (addr < base + length);
  endfunction

  always_comb begin
    target_o = soc_pkg::TARGET_NONE;
    if (in_window(bus_i.addr, soc_pkg::DRAM_BASE, soc_pkg::DRAM_LENGTH)) begin
      target_o = soc_pkg::TARGET_L2;
    end else if (in_window(bus_i.addr, soc_pkg::UART_BASE, soc_pkg::UART_LENGTH)) begin
      target_o = soc_pkg::TARGET_UART;
    end else if (in_window(bus_i.addr, soc_pkg::CTRL_BASE, soc_pkg::CTRL_LENGTH)) begin
      target_o = soc_pkg::TARGET_CTRL;
    end
  end

  // Grant held off only while our own UART transfer is in flight
  assign gnt_o  = ~(uart_pend_q & busy_i);
  assign accept = req_i & gnt_o;

  assign l2_sel_o   = accept & (target_o == soc_pkg::TARGET_L2);
  assign uart_sel_o = accept & (target_o == soc_pkg::TARGET_UART);
  assign ctrl_sel_o = accept & (target_o == soc_pkg::TARGET_CTRL);
  assign bus_o      = bus_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      uart_pend_q <= 1'b0;
    end else if (uart_sel_o) begin
      uart_pend_q <= 1'b1;
    end else if (uart_pend_q && !busy_i) begin
      uart_pend_q <= 1'b0;
    end
  end

endmodule

// ==== logic/soc_l2_mem.sv ====
/*
 * L2 scratch memory
 * Single port word array with byte enables, answers one cycle
 * after the select and aliases modulo its depth
 */

`timescale 1ns/1ps

module soc_l2_mem #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic              clk_i,
  input  logic              sel_i,
  input  soc_pkg::bus_req_t bus_i,
  output logic              valid_o,
  output soc_pkg::bus_rsp_t rsp_o
);

  localparam int unsigned IdxW = $clog2(L2NumWords);
  localparam int unsigned OffW = $clog2(soc_pkg::STRB_W);

  logic [soc_pkg::DATA_W-1:0] mem_q [L2NumWords];
  logic [soc_pkg::DATA_W-1:0] rdata_q;
  logic [IdxW-1:0]            idx;

  // Word index sits right above the byte offset
  assign idx = bus_i.addr[OffW +: IdxW];

  always_ff @(posedge clk_i) begin
    valid_o <= sel_i;
    if (sel_i) begin
      // Old word comes back on writes too
      rdata_q <= mem_q[idx];
      if (bus_i.we) begin
        for (int b = 0; b < soc_pkg::STRB_W; b++) begin
          if (bus_i.be[b]) begin
            mem_q[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = 1'b0;

endmodule

// ==== logic/soc_ctrl_regs.sv ====
/*
 * SoC control registers
 * Exit code and counter enable registers plus a one-cycle event
 * trigger, all behind the control window
 */

`timescale 1ns/1ps

module soc_ctrl_regs (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       sel_i,
  input  soc_pkg::bus_req_t          bus_i,
  output logic                       valid_o,
  output soc_pkg::bus_rsp_t          rsp_o,
  output logic [soc_pkg::DATA_W-1:0] exit_o,
  output logic [soc_pkg::DATA_W-1:0] hw_cnt_en_o,
  output logic [soc_pkg::DATA_W-1:0] event_o
);

  logic [soc_pkg::DATA_W-1:0] exit_q;
  logic [soc_pkg::DATA_W-1:0] cnt_en_q;
  logic [soc_pkg::DATA_W-1:0] event_q;
  logic                       valid_q;
  soc_pkg::bus_rsp_t          rsp_q;
  soc_pkg::ctrl_reg_e         offset;

  assign offset = soc_pkg::ctrl_reg_e'(bus_i.addr[11:0]);

  function automatic logic [soc_pkg::DATA_W-1:0] merge(logic [soc_pkg::DATA_W-1:0] old_w,
                                                      logic [soc_pkg::DATA_W-1:0] new_w,
                                                      logic [soc_pkg::STRB_W-1:0] be);
    logic [soc_pkg::DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < soc_pkg::STRB_W; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q  <= 1'b0;
      exit_q   <= '0;
      cnt_en_q <= '0;
      event_q  <= '0;
    end else begin
      valid_q <= sel_i;
      // Event holds for a single cycle only
      event_q <= '0;
      if (sel_i && bus_i.we) begin
        case (offset)
          soc_pkg::CTRL_EXIT:      exit_q   <= merge(exit_q, bus_i.wdata, bus_i.be);
          soc_pkg::CTRL_HW_CNT_EN: cnt_en_q <= merge(cnt_en_q, bus_i.wdata, bus_i.be);
          soc_pkg::CTRL_EVENT:     event_q  <= bus_i.wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      case (offset)
        soc_pkg::CTRL_EXIT:      rsp_q <= '{rdata: exit_q, err: 1'b0};
        soc_pkg::CTRL_HW_CNT_EN: rsp_q <= '{rdata: cnt_en_q, err: 1'b0};
        soc_pkg::CTRL_EVENT:     rsp_q <= '{rdata: '0, err: 1'b0};
        default:                 rsp_q <= '{rdata: '0, err: 1'b1};
      endcase
    end
  end

  assign valid_o     = valid_q;
  assign rsp_o       = rsp_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;
  assign event_o     = event_q;

endmodule

// ==== logic/soc_apb_bridge.sv ====
/*
 * Host to APB bridge for the UART
 * Runs one setup/access transfer per accepted request and keeps the
 * fabric busy until the response is handed back
 */

`timescale 1ns/1ps

module soc_apb_bridge (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              sel_i,
  input  soc_pkg::bus_req_t bus_i,
  output logic              busy_o,
  output logic              valid_o,
  output soc_pkg::bus_rsp_t rsp_o,
  output soc_pkg::apb_req_t apb_req_o,
  input  soc_pkg::apb_rsp_t apb_rsp_i
);

  soc_pkg::apb_state_e                state_q;
  logic                               valid_q;
  logic                               we_q;
  logic [soc_pkg::ADDR_W-1:0]         paddr_q;
  logic [soc_pkg::APB_DATA_W-1:0]     pwdata_q;
  logic [soc_pkg::APB_DATA_W-1:0]     prdata_q;
  logic                               err_q;

  //////////////////////////////////////////////////
  // Transfer FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= soc_pkg::APB_IDLE;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        soc_pkg::APB_IDLE: begin
          if (sel_i) state_q <= soc_pkg::APB_SETUP;
        end
        soc_pkg::APB_SETUP: state_q <= soc_pkg::APB_ACCESS;
        soc_pkg::APB_ACCESS: begin
          if (apb_rsp_i.pready) begin
            state_q <= soc_pkg::APB_IDLE;
            valid_q <= 1'b1;
          end
        end
        default: state_q <= soc_pkg::APB_IDLE;
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (state_q == soc_pkg::APB_IDLE && sel_i) begin
      we_q     <= bus_i.we;
      paddr_q  <= bus_i.addr & (soc_pkg::UART_LENGTH - 1);
      pwdata_q <= bus_i.wdata[soc_pkg::APB_DATA_W-1:0];
    end
    if (state_q == soc_pkg::APB_ACCESS && apb_rsp_i.pready) begin
      prdata_q <= apb_rsp_i.prdata;
      err_q    <= apb_rsp_i.pslverr;
    end
  end

  assign apb_req_o.psel    = (state_q != soc_pkg::APB_IDLE);
  assign apb_req_o.penable = (state_q == soc_pkg::APB_ACCESS);
  assign apb_req_o.pwrite  = we_q;
  assign apb_req_o.paddr   = paddr_q;
  assign apb_req_o.pwdata  = pwdata_q;

  assign busy_o      = (state_q != soc_pkg::APB_IDLE);
  assign valid_o     = valid_q;
  assign rsp_o.rdata = {{(soc_pkg::DATA_W - soc_pkg::APB_DATA_W){1'b0}}, prdata_q};
  assign rsp_o.err   = err_q;

endmodule

// ==== logic/soc_resp_mux.sv ====
/*
 * Response merge
 * Forwards the single valid target response and answers unmapped
 * requests with an error one cycle after acceptance
 */

`timescale 1ns/1ps

module soc_resp_mux (
  input  logic              clk_i,
  input  logic              reset_i,
  input  soc_pkg::target_e  target_i,
  input  logic              accept_i,
  input  logic              l2_valid_i,
  input  logic              ctrl_valid_i,
  input  logic              uart_valid_i,
  input  soc_pkg::bus_rsp_t l2_rsp_i,
  input  soc_pkg::bus_rsp_t ctrl_rsp_i,
  input  soc_pkg::bus_rsp_t uart_rsp_i,
  output logic              rvalid_o,
  output soc_pkg::bus_rsp_t rsp_o
);

  logic none_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      none_q <= 1'b0;
    end else begin
      none_q <= accept_i && (target_i == soc_pkg::TARGET_NONE);
    end
  end

  assign rvalid_o = l2_valid_i | ctrl_valid_i | uart_valid_i | none_q;

  // At most one source is valid per cycle
  always_comb begin
    if (l2_valid_i) rsp_o = l2_rsp_i;
    else if (ctrl_valid_i) rsp_o = ctrl_rsp_i;
    else if (uart_valid_i) rsp_o = uart_rsp_i;
    else rsp_o = '{rdata: '0, err: 1'b1};
  end

endmodule

// ==== logic/soc_top.sv ====
/*
 * SoC fabric top level
 * Host port decode feeding L2 scratch memory, control registers and
 * the UART APB bridge, with a merged in-order response path
 */

`timescale 1ns/1ps

module soc_top #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       req_i,
  input  soc_pkg::bus_req_t          bus_i,
  output logic                       gnt_o,
  output logic                       rvalid_o,
  output soc_pkg::bus_rsp_t          rsp_o,
  output logic [soc_pkg::DATA_W-1:0] exit_o,
  output logic [soc_pkg::DATA_W-1:0] hw_cnt_en_o,
  output logic [soc_pkg::DATA_W-1:0] event_o,
  output soc_pkg::apb_req_t          apb_req_o,
  input  soc_pkg::apb_rsp_t          apb_rsp_i
);

  logic              l2_sel, ctrl_sel, uart_sel;
  logic              l2_valid, ctrl_valid, uart_valid;
  logic              uart_busy;
  soc_pkg::target_e  target;
  soc_pkg::bus_req_t bus;
  soc_pkg::bus_rsp_t l2_rsp, ctrl_rsp, uart_rsp;

  //////////////////////////////////////////////////
  // Decode and targets
  //////////////////////////////////////////////////

  soc_addr_decode u_decode (
    .clk_i     (clk_i    ),
    .reset_i   (reset_i  ),
    .req_i     (req_i    ),
    .bus_i     (bus_i    ),
    .busy_i    (uart_busy),
    .gnt_o     (gnt_o    ),
    .l2_sel_o  (l2_sel   ),
    .ctrl_sel_o(ctrl_sel ),
    .uart_sel_o(uart_sel ),
    .target_o  (target   ),
    .bus_o     (bus      )
  );

  soc_l2_mem #(
    .L2NumWords(L2NumWords)
  ) u_l2 (
    .clk_i  (clk_i   ),
    .sel_i  (l2_sel  ),
    .bus_i  (bus     ),
    .valid_o(l2_valid),
    .rsp_o  (l2_rsp  )
  );

  soc_ctrl_regs u_ctrl (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .sel_i      (ctrl_sel   ),
    .bus_i      (bus        ),
    .valid_o    (ctrl_valid ),
    .rsp_o      (ctrl_rsp   ),
    .exit_o     (exit_o     ),
    .hw_cnt_en_o(hw_cnt_en_o),
    .event_o    (event_o    )
  );

  soc_apb_bridge u_apb (
    .clk_i    (clk_i     ),
    .reset_i  (reset_i   ),
    .sel_i    (uart_sel  ),
    .bus_i    (bus       ),
    .busy_o   (uart_busy ),
    .valid_o  (uart_valid),
    .rsp_o    (uart_rsp  ),
    .apb_req_o(apb_req_o ),
    .apb_rsp_i(apb_rsp_i )
  );

  // Response path
  soc_resp_mux u_resp (
    .clk_i       (clk_i          ),
    .reset_i     (reset_i        ),
    .target_i    (target         ),
    .accept_i    (req_i & gnt_o  ),
    .l2_valid_i  (l2_valid       ),
    .ctrl_valid_i(ctrl_valid     ),
    .uart_valid_i(uart_valid     ),
    .l2_rsp_i    (l2_rsp         ),
    .ctrl_rsp_i  (ctrl_rsp       ),
    .uart_rsp_i  (uart_rsp       ),
    .rvalid_o    (rvalid_o       ),
    .rsp_o       (rsp_o          )
  );

endmodule

// ==== bench/tb_clk_gen.sv ====
/*
 * Testbench clock and reset
 * Free running clock, reset held high for the first cycles
 */

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned HalfPeriod  = 2,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Released just after an edge, like the other inputs
  initial begin
    reset_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

// ==== bench/tb_soc_top.sv ====
/*
 * SoC fabric testbench
 * Directed tests on the host port, with an APB slave model that
 * stands in for the UART
 */

`timescale 1ns/1ps

module tb_soc_top;

  localparam int L2Words = 256;
  localparam int Timeout = 64;

  logic                       clk;
  logic                       reset;
  logic                       req;
  soc_pkg::bus_req_t          bus;
  logic                       gnt;
  logic                       rvalid;
  soc_pkg::bus_rsp_t          rsp;
  logic [soc_pkg::DATA_W-1:0] exit_w;
  logic [soc_pkg::DATA_W-1:0] hw_cnt_en;
  logic [soc_pkg::DATA_W-1:0] event_w;
  soc_pkg::apb_req_t          apb_req;
  soc_pkg::apb_rsp_t          apb_rsp;

  integer                     seed = 68524;
  logic [soc_pkg::DATA_W-1:0] l2_model [L2Words];
  bit                         l2_known [L2Words];
  logic [31:0]                apb_mem [16];
  int unsigned                apb_waits;

  tb_clk_gen #(
    .HalfPeriod (2 ),
    .ResetCycles(10)
  ) u_clk (
    .clk_o  (clk  ),
    .reset_o(reset)
  );

  soc_top #(
    .L2NumWords(L2Words)
  ) u_dut (
    .clk_i      (clk      ),
    .reset_i    (reset    ),
    .req_i      (req      ),
    .bus_i      (bus      ),
    .gnt_o      (gnt      ),
    .rvalid_o   (rvalid   ),
    .rsp_o      (rsp      ),
    .exit_o     (exit_w   ),
    .hw_cnt_en_o(hw_cnt_en),
    .event_o    (event_w  ),
    .apb_req_o  (apb_req  ),
    .apb_rsp_i  (apb_rsp  )
  );

  //////////////////////////////////////////////////
  // APB slave model
  //////////////////////////////////////////////////

  function automatic logic [31:0] apb_fill(input int idx);
    return 32'hA5C3_0000 ^ (idx * 32'h0101_0101);
  endfunction

  // Random wait states picked in the setup phase
  always @(posedge clk) begin
    #1;
    apb_rsp = '0;
    if (apb_req.psel && !apb_req.penable) begin
      apb_waits = $random(seed) & 3;
    end else if (apb_req.psel && apb_req.penable) begin
      if (apb_waits != 0) begin
        apb_waits = apb_waits - 1;
      end else begin
        apb_rsp.pready = 1'b1;
        if (apb_req.paddr[11:0] == 12'hFFC) begin
          apb_rsp.pslverr = 1'b1;
        end else if (apb_req.pwrite) begin
          apb_mem[apb_req.paddr[5:2]] = apb_req.pwdata;
        end else begin
          apb_rsp.prdata = apb_mem[apb_req.paddr[5:2]];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Reporting and compare tasks
  //////////////////////////////////////////////////

  task automatic stop_on_error();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", Timeout, what);
    stop_on_error();
  endtask

  task automatic check_word(input string name, input logic [soc_pkg::DATA_W-1:0] exp,
                            input logic [soc_pkg::DATA_W-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_rsp(input string name, input soc_pkg::bus_rsp_t exp,
                           input soc_pkg::bus_rsp_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected rdata=%h err=%b actual rdata=%h err=%b",
               name, exp.rdata, exp.err, act.rdata, act.err);
      stop_on_error();
    end
  endtask

  task automatic check_apb(input string name, input soc_pkg::apb_req_t exp,
                           input soc_pkg::apb_req_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected sel=%b en=%b wr=%b addr=%h wdata=%h",
               name, exp.psel, exp.penable, exp.pwrite, exp.paddr, exp.pwdata,
               " actual sel=%b en=%b wr=%b addr=%h wdata=%h",
               act.psel, act.penable, act.pwrite, act.paddr, act.pwdata);
      stop_on_error();
    end
  endtask

  //////////////////////////////////////////////////
  // Host port helpers
  //////////////////////////////////////////////////

  function automatic soc_pkg::bus_req_t make_req(input logic we,
                                                 input logic [soc_pkg::ADDR_W-1:0] addr,
                                                 input logic [soc_pkg::DATA_W-1:0] wdata,
                                                 input logic [soc_pkg::STRB_W-1:0] be);
    soc_pkg::bus_req_t r;
    r.we    = we;
    r.addr  = addr;
    r.wdata = wdata;
    r.be    = be;
    return r;
  endfunction

  function automatic soc_pkg::bus_rsp_t make_rsp(input logic [soc_pkg::DATA_W-1:0] rdata,
                                                 input logic err);
    soc_pkg::bus_rsp_t r;
    r.rdata = rdata;
    r.err   = err;
    return r;
  endfunction

  function automatic logic [soc_pkg::DATA_W-1:0] byte_merge(
      input logic [soc_pkg::DATA_W-1:0] old_w, input logic [soc_pkg::DATA_W-1:0] new_w,
      input logic [soc_pkg::STRB_W-1:0] be);
    logic [soc_pkg::DATA_W-1:0] mask;
    for (int i = 0; i < soc_pkg::STRB_W; i++) begin
      mask[8*i +: 8] = {8{be[i]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic [soc_pkg::ADDR_W-1:0] ctrl_addr(input logic [11:0] offset);
    return soc_pkg::CTRL_BASE | offset;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_reset_done();
    int waited;
    waited = 0;
    while (reset !== 1'b0) begin
      if (waited >= Timeout) report_timeout("reset release");
      @(negedge clk);
      waited++;
    end
    next_cycle();
  endtask

  // Leaves the bus idle in the cycle after acceptance
  task automatic start_req(input soc_pkg::bus_req_t r);
    int waited;
    waited = 0;
    req = 1'b1;
    bus = r;
    #1;
    while (gnt !== 1'b1) begin
      if (waited >= Timeout) report_timeout("grant");
      @(posedge clk);
      #2;
      waited++;
    end
    next_cycle();
    req = 1'b0;
    bus = '0;
  endtask

  // Grant must stay low for every cycle without a response
  task automatic wait_rsp(input string name, output soc_pkg::bus_rsp_t got, output int waited);
    waited = 0;
    while (rvalid !== 1'b1) begin
      check_word({name, " grant held"}, '0, {63'b0, gnt});
      if (waited >= Timeout) report_timeout({name, " response"});
      next_cycle();
      waited++;
    end
    got = rsp;
  endtask

  task automatic access_one_cycle(input string name, input soc_pkg::bus_req_t r,
                                  input soc_pkg::bus_rsp_t exp);
    soc_pkg::bus_rsp_t got;
    int                waited;
    start_req(r);
    wait_rsp(name, got, waited);
    check_word({name, " latency"}, '0, waited);
    check_rsp(name, exp, got);
  endtask

  // One request per cycle, each response checked in the following cycle
  task automatic l2_burst(input string name, input logic we, input logic full_be,
                          input int first, input int count);
    soc_pkg::bus_req_t r;
    soc_pkg::bus_rsp_t prev_exp;
    logic              prev_known;
    logic [31:0]       rnd;
    int                idx;
    int                k;
    for (k = 0; k <= count; k++) begin
      if (k < count) begin
        idx = (first + k) % L2Words;
        rnd = $random(seed);
        r = make_req(we, soc_pkg::DRAM_BASE + (first + k) * 8,
                     {$random(seed), $random(seed)}, full_be ? 8'hFF : rnd[7:0]);
        req = 1'b1;
        bus = r;
      end else begin
        req = 1'b0;
        bus = '0;
      end
      #1;
      if (k < count) check_word({name, " grant"}, 64'd1, {63'b0, gnt});
      if (k > 0) begin
        check_word({name, " rvalid"}, 64'd1, {63'b0, rvalid});
        if (prev_known) check_rsp(name, prev_exp, rsp);
        else check_word({name, " err"}, '0, {63'b0, rsp.err});
      end
      if (k < count) begin
        prev_exp   = make_rsp(l2_model[idx], 1'b0);
        prev_known = l2_known[idx];
        if (we) begin
          l2_model[idx] = byte_merge(l2_model[idx], r.wdata, r.be);
          l2_known[idx] = l2_known[idx] | full_be;
        end
      end
      next_cycle();
    end
    check_word({name, " single pulse"}, '0, {63'b0, rvalid});
  endtask

  task automatic uart_transfer(input string name, input logic we, input logic [11:0] offset,
                               input logic [soc_pkg::DATA_W-1:0] wdata,
                               output soc_pkg::bus_rsp_t got);
    soc_pkg::apb_req_t exp;
    int                waited;
    exp.psel    = 1'b1;
    exp.penable = 1'b0;
    exp.pwrite  = we;
    exp.paddr   = {20'h0, offset};
    exp.pwdata  = wdata[31:0];
    start_req(make_req(we, soc_pkg::UART_BASE | offset, wdata, 8'hFF));
    check_apb({name, " setup"}, exp, apb_req);
    check_word({name, " setup grant"}, '0, {63'b0, gnt});
    next_cycle();
    exp.penable = 1'b1;
    check_apb({name, " access"}, exp, apb_req);
    wait_rsp(name, got, waited);
    // Busy drops together with the response
    check_word({name, " grant back"}, 64'd1, {63'b0, gnt});
    next_cycle();
    check_word({name, " single pulse"}, '0, {63'b0, rvalid});
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    check_word("reset rvalid", '0, {63'b0, rvalid});
    check_word("reset psel", '0, {63'b0, apb_req.psel});
    check_word("reset penable", '0, {63'b0, apb_req.penable});
    check_word("reset event", '0, event_w);
    check_word("reset exit", '0, exit_w);
    check_word("reset hw_cnt_en", '0, hw_cnt_en);
    check_word("reset grant", 64'd1, {63'b0, gnt});
  endtask

  task automatic test_l2();
    l2_burst("l2 full writes", 1'b1, 1'b1, 0, 8);
    l2_burst("l2 partial writes", 1'b1, 1'b0, 0, 8);
    l2_burst("l2 partial reads", 1'b0, 1'b0, 0, 8);
    // Word 256 wraps onto word 0
    l2_burst("l2 alias read", 1'b0, 1'b0, L2Words, 1);
    l2_burst("l2 alias write", 1'b1, 1'b1, L2Words, 2);
    l2_burst("l2 alias readback", 1'b0, 1'b0, 0, 2);
  endtask

  task automatic test_ctrl();
    soc_pkg::bus_rsp_t          got;
    int                         waited;
    logic [soc_pkg::DATA_W-1:0] exit_m;
    logic [soc_pkg::DATA_W-1:0] cnt_m;
    logic [soc_pkg::DATA_W-1:0] evt;
    exit_m = 64'h0123_4567_89AB_CDEF;
    access_one_cycle("ctrl exit write", make_req(1'b1, ctrl_addr(soc_pkg::CTRL_EXIT),
                     exit_m, 8'hFF), make_rsp('0, 1'b0));
    check_word("ctrl exit_o", exit_m, exit_w);
    access_one_cycle("ctrl exit partial", make_req(1'b1, ctrl_addr(soc_pkg::CTRL_EXIT),
                     64'hFFFF_FFFF_FFFF_FFFF, 8'h0F), make_rsp(exit_m, 1'b0));
    exit_m = byte_merge(exit_m, 64'hFFFF_FFFF_FFFF_FFFF, 8'h0F);
    check_word("ctrl exit_o partial", exit_m, exit_w);
    access_one_cycle("ctrl exit read", make_req(1'b0, ctrl_addr(soc_pkg::CTRL_EXIT),
                     '0, 8'hFF), make_rsp(exit_m, 1'b0));
    cnt_m = 64'h0000_0000_0000_0005;
    access_one_cycle("ctrl cnt write", make_req(1'b1, ctrl_addr(soc_pkg::CTRL_HW_CNT_EN),
                     cnt_m, 8'hFF), make_rsp('0, 1'b0));
    check_word("ctrl hw_cnt_en_o", cnt_m, hw_cnt_en);
    access_one_cycle("ctrl cnt read", make_req(1'b0, ctrl_addr(soc_pkg::CTRL_HW_CNT_EN),
                     '0, 8'hFF), make_rsp(cnt_m, 1'b0));
    // Event pulse lasts one cycle
    evt = 64'h0000_00A5_0000_005A;
    check_word("ctrl event idle", '0, event_w);
    start_req(make_req(1'b1, ctrl_addr(soc_pkg::CTRL_EVENT), evt, 8'hFF));
    check_word("ctrl event pulse", evt, event_w);
    wait_rsp("ctrl event write", got, waited);
    check_word("ctrl event latency", '0, waited);
    check_rsp("ctrl event write", make_rsp('0, 1'b0), got);
    next_cycle();
    check_word("ctrl event cleared", '0, event_w);
    access_one_cycle("ctrl event read", make_req(1'b0, ctrl_addr(soc_pkg::CTRL_EVENT),
                     '0, 8'hFF), make_rsp('0, 1'b0));
    access_one_cycle("ctrl bad write", make_req(1'b1, ctrl_addr(12'h018), '1, 8'hFF),
                     make_rsp('0, 1'b1));
    access_one_cycle("ctrl bad read", make_req(1'b0, ctrl_addr(12'h018), '0, 8'hFF),
                     make_rsp('0, 1'b1));
    check_word("ctrl exit kept", exit_m, exit_w);
    check_word("ctrl cnt kept", cnt_m, hw_cnt_en);
  endtask

  task automatic test_uart();
    soc_pkg::bus_rsp_t          got;
    logic [soc_pkg::DATA_W-1:0] wdata;
    wdata = 64'hFEED_FACE_1234_5678;
    uart_transfer("uart write", 1'b1, 12'h004, wdata, got);
    check_rsp("uart write", make_rsp('0, 1'b0), got);
    uart_transfer("uart read", 1'b0, 12'h004, '0, got);
    check_rsp("uart read", make_rsp({32'h0, wdata[31:0]}, 1'b0), got);
    uart_transfer("uart read fill", 1'b0, 12'h008, '0, got);
    check_rsp("uart read fill", make_rsp({32'h0, apb_fill(2)}, 1'b0), got);
  endtask

  task automatic test_slverr();
    soc_pkg::bus_rsp_t got;
    uart_transfer("uart slverr read", 1'b0, 12'hFFC, '0, got);
    check_rsp("uart slverr read", make_rsp('0, 1'b1), got);
    uart_transfer("uart slverr write", 1'b1, 12'hFFC, 64'h1111_2222, got);
    check_rsp("uart slverr write", make_rsp('0, 1'b1), got);
  endtask

  task automatic test_unmapped();
    soc_pkg::bus_rsp_t          got;
    int                         waited;
    logic [soc_pkg::DATA_W-1:0] exit_m;
    logic [soc_pkg::DATA_W-1:0] cnt_m;
    exit_m = exit_w;
    cnt_m  = hw_cnt_en;
    // Low bits would hit L2 word 0 if routed there
    start_req(make_req(1'b1, 32'h0000_1000, '1, 8'hFF));
    check_word("unmapped no apb", '0, {63'b0, apb_req.psel});
    wait_rsp("unmapped write", got, waited);
    check_word("unmapped latency", '0, waited);
    check_rsp("unmapped write", make_rsp('0, 1'b1), got);
    access_one_cycle("unmapped read", make_req(1'b0, 32'h0000_1000, '0, 8'hFF),
                     make_rsp('0, 1'b1));
    next_cycle();
    check_word("unmapped exit kept", exit_m, exit_w);
    check_word("unmapped cnt kept", cnt_m, hw_cnt_en);
    l2_burst("unmapped l2 intact", 1'b0, 1'b1, 0, 1);
  endtask

  initial begin
    req     = 1'b0;
    bus     = '0;
    apb_rsp = '0;
    for (int i = 0; i < 16; i++) begin
      apb_mem[i] = apb_fill(i);
    end
    wait_reset_done();
    test_reset();
    test_l2();
    test_ctrl();
    test_uart();
    test_slverr();
    test_unmapped();
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== build.f ====
logic/soc_pkg.sv
logic/soc_addr_decode.sv
logic/soc_l2_mem.sv
logic/soc_ctrl_regs.sv
logic/soc_apb_bridge.sv
logic/soc_resp_mux.sv
logic/soc_top.sv
bench/tb_clk_gen.sv
bench/tb_soc_top.sv

// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - logic/soc_pkg.sv
  - logic/soc_addr_decode.sv
  - logic/soc_l2_mem.sv
  - logic/soc_ctrl_regs.sv
  - logic/soc_apb_bridge.sv
  - logic/soc_resp_mux.sv
  - logic/soc_top.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_soc_top.sv
